// File: tft_pkg.sv
// Shared types and constants for the TFT start-up and pixel path.
// Modules import it inside their bodies and use scoped names in their headers.
package tft_pkg;

    // Kind of one start-up ROM entry whose payload is the byte beside it
    typedef enum logic [1:0] {
        entry_cmd  = 2'b00,
        entry_data = 2'b01,
        entry_wait = 2'b10
    } entry_kind_t;

    // Number of entries in the start-up ROM, waits included
    localparam int init_len = 44;

    // Clocks per millisecond at 10 MHz
    localparam int default_cycles_per_ms = 10000;

    // Panel command that opens a pixel write into the current window
    localparam logic [7:0] cmd_mem_write = 8'h2C;

    // Red, green and blue take 6 bits each with red in the top bits
    localparam int pixel_width = 18;

    // SPI byte transmitter states
    typedef enum logic [1:0] {
        spi_idle,
        spi_shift,
        spi_gap
    } spi_state_t;

endpackage

// File: ms_delay.sv
`timescale 1ns/100ps
// Millisecond countdown used for start-up waits.
// Pulse set with ms loaded, then wait until free is high again.
module ms_delay #(
    parameter int cycles_per_ms = tft_pkg::default_cycles_per_ms
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       set,
    input  logic [7:0] ms,
    output logic       free
);
    typedef logic [$clog2(cycles_per_ms + 1)-1:0] pre_t;

    logic [7:0] ms_cnt;
    pre_t       pre;

    assign free = (ms_cnt == 8'd0) && (pre == pre_t'(0));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ms_cnt <= 8'd0;
            pre    <= pre_t'(0);
        end
        else if (set)
        begin
            ms_cnt <= ms;
            pre    <= (ms == 8'd0) ? pre_t'(0) : pre_t'(cycles_per_ms - 1);
        end
        else if (pre != pre_t'(0))
        begin
            pre <= pre - pre_t'(1);
        end
        else if (ms_cnt != 8'd0)
        begin
            // Reload the prescaler unless this was the last millisecond
            ms_cnt <= ms_cnt - 8'd1;
            if (ms_cnt != 8'd1)
                pre <= pre_t'(cycles_per_ms - 1);
        end
    end

    a_set_when_free: assert property (@(posedge clk) disable iff (rst) set |-> free)
        else $error("ms_delay reloaded while a wait was still running");

endmodule

// File: tft_spi_tx.sv
`timescale 1ns/100ps
// Write-only SPI byte transmitter in mode 0 with sck at half the clock rate.
// Pulse transmit with data and dc_in while busy is low.
module tft_spi_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       transmit,
    input  logic       dc_in,
    input  logic [7:0] data,
    output logic       busy,
    output logic       cs,
    output logic       sck,
    output logic       mosi,
    output logic       dc
);
    import tft_pkg::*;

    spi_state_t state;
    logic [7:0] shreg;
    logic [3:0] half_cnt;

    assign mosi = shreg[7];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= spi_idle;
            busy     <= 1'b0;
            cs       <= 1'b1;
            sck      <= 1'b0;
            dc       <= 1'b0;
            half_cnt <= 4'd0;
        end
        else
        begin
            case (state)
                spi_idle:
                begin
                    if (transmit)
                    begin
                        state    <= spi_shift;
                        busy     <= 1'b1;
                        cs       <= 1'b0;
                        dc       <= dc_in;
                        half_cnt <= 4'd0;
                    end
                end
                spi_shift:
                begin
                    // Even half periods raise sck, odd ones drop it
                    sck      <= ~half_cnt[0];
                    half_cnt <= half_cnt + 4'd1;
                    if (half_cnt == 4'd15)
                    begin
                        cs    <= 1'b1;
                        state <= spi_gap;
                    end
                end
                spi_gap:
                begin
                    busy  <= 1'b0;
                    state <= spi_idle;
                end
                default:
                begin
                    state <= spi_idle;
                end
            endcase
        end
    end

    // The next bit moves onto mosi on each falling edge of sck
    always_ff @(posedge clk)
    begin
        if (state == spi_idle && transmit)
            shreg <= data;
        else if (state == spi_shift && half_cnt[0])
            shreg <= {shreg[6:0], 1'b0};
    end

    a_sck_inside_cs: assert property (@(posedge clk) disable iff (rst) sck |-> !cs)
        else $error("sck pulsed while cs was high");

endmodule

// File: tft_init.sv
`timescale 1ns/100ps
// Start-up sequencer that walks a fixed ROM of commands, data and waits.
// It raises done once the full-screen window has been selected.
module tft_init #(
    parameter int cycles_per_ms = tft_pkg::default_cycles_per_ms
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       busy,
    output logic       transmit,
    output logic       dc,
    output logic [7:0] data,
    output logic       done
);
    import tft_pkg::*;

    logic [5:0]  index;
    logic [9:0]  rom_entry;
    entry_kind_t rom_kind;
    logic [7:0]  rom_byte;
    logic        at_end;
    logic        delay_set;
    logic [7:0]  delay_ms;
    logic        delay_free;

    always_comb
    begin
        case (index)
            6'd0:    rom_entry = {entry_wait, 8'hFF};
            // Power control 1 and 2
            6'd1:    rom_entry = {entry_cmd,  8'hC0};
            6'd2:    rom_entry = {entry_data, 8'h17};
            6'd3:    rom_entry = {entry_data, 8'h15};
            6'd4:    rom_entry = {entry_cmd,  8'hC1};
            6'd5:    rom_entry = {entry_data, 8'h41};
            // VCOM
            6'd6:    rom_entry = {entry_cmd,  8'hC5};
            6'd7:    rom_entry = {entry_data, 8'h00};
            6'd8:    rom_entry = {entry_data, 8'h12};
            6'd9:    rom_entry = {entry_data, 8'h80};
            // Memory access order, then 18 bits per pixel
            6'd10:   rom_entry = {entry_cmd,  8'h36};
            6'd11:   rom_entry = {entry_data, 8'h48};
            6'd12:   rom_entry = {entry_cmd,  8'h3A};
            6'd13:   rom_entry = {entry_data, 8'h66};
            6'd14:   rom_entry = {entry_cmd,  8'hB0};
            6'd15:   rom_entry = {entry_data, 8'h80};
            6'd16:   rom_entry = {entry_cmd,  8'hB1};
            6'd17:   rom_entry = {entry_data, 8'hA0};
            6'd18:   rom_entry = {entry_cmd,  8'hB6};
            6'd19:   rom_entry = {entry_data, 8'h02};
            6'd20:   rom_entry = {entry_data, 8'h02};
            6'd21:   rom_entry = {entry_cmd,  8'hE9};
            6'd22:   rom_entry = {entry_data, 8'h00};
            6'd23:   rom_entry = {entry_cmd,  8'hF7};
            6'd24:   rom_entry = {entry_data, 8'hA9};
            6'd25:   rom_entry = {entry_data, 8'h51};
            6'd26:   rom_entry = {entry_data, 8'h2C};
            6'd27:   rom_entry = {entry_data, 8'h82};
            // Sleep out needs a long settle before display on
            6'd28:   rom_entry = {entry_cmd,  8'h11};
            6'd29:   rom_entry = {entry_wait, 8'hFF};
            6'd30:   rom_entry = {entry_cmd,  8'h29};
            6'd31:   rom_entry = {entry_cmd,  8'h21};
            6'd32:   rom_entry = {entry_cmd,  8'h34};
            6'd33:   rom_entry = {entry_wait, 8'hFF};
            // Columns 0 to 319 and pages 0 to 479
            6'd34:   rom_entry = {entry_cmd,  8'h2A};
            6'd35:   rom_entry = {entry_data, 8'h00};
            6'd36:   rom_entry = {entry_data, 8'h00};
            6'd37:   rom_entry = {entry_data, 8'h01};
            6'd38:   rom_entry = {entry_data, 8'h3F};
            6'd39:   rom_entry = {entry_cmd,  8'h2B};
            6'd40:   rom_entry = {entry_data, 8'h00};
            6'd41:   rom_entry = {entry_data, 8'h00};
            6'd42:   rom_entry = {entry_data, 8'h01};
            6'd43:   rom_entry = {entry_data, 8'hDF};
            default: rom_entry = {entry_cmd,  8'h00};
        endcase
    end

    assign rom_kind = entry_kind_t'(rom_entry[9:8]);
    assign rom_byte = rom_entry[7:0];
    assign at_end   = (index == 6'(init_len));

    ms_delay #(
        .cycles_per_ms(cycles_per_ms)
    ) ms_delay_i (
        .clk (clk),
        .rst (rst),
        .set (delay_set),
        .ms  (delay_ms),
        .free(delay_free)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            index     <= 6'd0;
            transmit  <= 1'b0;
            dc        <= 1'b0;
            data      <= 8'h00;
            delay_set <= 1'b0;
            done      <= 1'b0;
        end
        else
        begin
            // Byte lines idle at zero so the top can OR both requesters
            transmit  <= 1'b0;
            dc        <= 1'b0;
            data      <= 8'h00;
            delay_set <= 1'b0;
            if (!at_end && !busy && !transmit && !delay_set && delay_free)
            begin
                if (rom_kind == entry_wait)
                begin
                    delay_set <= 1'b1;
                end
                else
                begin
                    transmit <= 1'b1;
                    dc       <= (rom_kind == entry_data);
                    data     <= rom_byte;
                end
                index <= index + 6'd1;
            end
            if (at_end && !transmit)
                done <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!at_end && rom_kind == entry_wait)
            delay_ms <= rom_byte;
    end

    a_no_transmit_busy: assert property (@(posedge clk) disable iff (rst) transmit |-> !busy)
        else $error("start-up byte requested while the SPI transmitter was busy");

endmodule

// File: tft_pixel_stream.sv
`timescale 1ns/100ps
// Pixel streamer that runs after start-up, sending memory-write when needed
// and then each 18-bit pixel as three bytes, red first.
module tft_pixel_stream (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            init_done,
    input  logic                            frame_start,
    input  logic                            busy,
    input  logic [tft_pkg::pixel_width-1:0] pixel,
    input  logic                            pixel_valid,
    output logic                            pixel_ready,
    output logic                            transmit,
    output logic                            dc,
    output logic [7:0]                      data
);
    import tft_pkg::*;

    logic                   need_cmd;
    logic                   active;
    logic [1:0]             step;
    logic [pixel_width-1:0] pix_reg;
    logic [5:0]             field;
    logic                   accept;
    logic                   issue;

    assign pixel_ready = init_done && !active && !busy && !transmit;
    assign accept      = pixel_valid && pixel_ready;
    assign issue       = active && !busy && !transmit;

    // Step 0 is the memory-write command, steps 1 to 3 are the colour bytes
    always_comb
    begin
        case (step)
            2'd1:    field = pix_reg[17:12];
            2'd2:    field = pix_reg[11:6];
            default: field = pix_reg[5:0];
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            need_cmd <= 1'b1;
            active   <= 1'b0;
            step     <= 2'd0;
            transmit <= 1'b0;
            dc       <= 1'b0;
            data     <= 8'h00;
        end
        else
        begin
            transmit <= 1'b0;
            dc       <= 1'b0;
            data     <= 8'h00;
            if (accept)
            begin
                active <= 1'b1;
                step   <= need_cmd ? 2'd0 : 2'd1;
            end
            else if (issue)
            begin
                transmit <= 1'b1;
                if (step == 2'd0)
                begin
                    data     <= cmd_mem_write;
                    need_cmd <= 1'b0;
                end
                else
                begin
                    dc   <= 1'b1;
                    data <= {field, 2'b00};
                end
                if (step == 2'd3)
                    active <= 1'b0;
                step <= step + 2'd1;
            end
            // A new frame wins over the command that is going out now
            if (frame_start)
                need_cmd <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            pix_reg <= pixel;
    end

endmodule

// File: tft_top.sv
`timescale 1ns/100ps
// Top level of the TFT panel driver in which start-up and pixel streaming share one
// SPI transmitter. Feed pixels on the valid/ready port once init_done is high.
module tft_top #(
    parameter int cycles_per_ms = tft_pkg::default_cycles_per_ms
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            frame_start,
    input  logic [tft_pkg::pixel_width-1:0] pixel,
    input  logic                            pixel_valid,
    output logic                            pixel_ready,
    output logic                            init_done,
    output logic                            cs,
    output logic                            sck,
    output logic                            mosi,
    output logic                            dc
);
    logic       spi_busy;
    logic       init_transmit;
    logic       init_dc;
    logic [7:0] init_data;
    logic       pix_transmit;
    logic       pix_dc;
    logic [7:0] pix_data;

    tft_init #(
        .cycles_per_ms(cycles_per_ms)
    ) tft_init_i (
        .clk     (clk),
        .rst     (rst),
        .busy    (spi_busy),
        .transmit(init_transmit),
        .dc      (init_dc),
        .data    (init_data),
        .done    (init_done)
    );

    tft_pixel_stream tft_pixel_stream_i (
        .clk        (clk),
        .rst        (rst),
        .init_done  (init_done),
        .frame_start(frame_start),
        .busy       (spi_busy),
        .pixel      (pixel),
        .pixel_valid(pixel_valid),
        .pixel_ready(pixel_ready),
        .transmit   (pix_transmit),
        .dc         (pix_dc),
        .data       (pix_data)
    );

    // Both requesters hold their byte lines at zero when idle
    tft_spi_tx tft_spi_tx_i (
        .clk     (clk),
        .rst     (rst),
        .transmit(init_transmit | pix_transmit),
        .dc_in   (init_dc | pix_dc),
        .data    (init_data | pix_data),
        .busy    (spi_busy),
        .cs      (cs),
        .sck     (sck),
        .mosi    (mosi),
        .dc      (dc)
    );

    a_single_requester: assert property (@(posedge clk) disable iff (rst)
        pix_transmit |-> (init_done && !init_transmit))
        else $error("pixel byte requested before start-up finished");

endmodule

// File: tft_checker.sv
`timescale 1ns/100ps
// Watches the TFT SPI pins, rebuilds each byte and compares it with tft_vectors.txt.
// Also checks the cs-high gaps across start-up waits and the init_done level.
module tft_checker (
    input  logic clk,
    input  logic rst,
    input  logic cs,
    input  logic sck,
    input  logic mosi,
    input  logic dc,
    input  logic init_done,
    input  logic pixel_ready,
    output int   checks,
    output int   errors,
    output logic finished
);
    import tft_pkg::*;

    // Three of the ROM entries are waits and put no byte on the link
    localparam int init_bytes = init_len - 3;
    localparam int vec_depth = 128;

    logic [23:0] vec [0:vec_depth-1];
    int          idx;
    int          group_errors;
    int          min_gap;
    int          gap_cnt;
    int          started;
    int          bit_cnt;
    logic [7:0]  shift_in;
    logic        prev_cs;
    logic        prev_sck;
    logic        done_seen;
    logic        level_flagged;

    task automatic report_error(input string msg);
        errors++;
        group_errors++;
        $display("error at %0d ns: %s", $time, msg);
    endtask

    // Steps over gap, stimulus and test-end entries up to the next expected byte
    task automatic skip_to_next_byte();
        logic [3:0] kind;
        kind = (idx < vec_depth) ? vec[idx][23:20] : 4'h0;
        while (!$isunknown(kind) && kind != 4'h0 && kind != 4'h1)
        begin
            if (kind == 4'h2)
                min_gap = int'(vec[idx][19:0]);
            else if (kind == 4'h6)
            begin
                $display("test %0d finished with %0d errors", vec[idx][7:0], group_errors);
                group_errors = 0;
            end
            idx++;
            kind = (idx < vec_depth) ? vec[idx][23:20] : 4'h0;
        end
        if (kind !== 4'h1)
            finished = 1'b1;
    endtask

    task automatic compare_byte(input logic [7:0] got, input logic got_dc);
        logic [23:0] expected;
        expected = (idx < vec_depth) ? vec[idx] : 24'h0;
        checks++;
        if (expected[23:20] !== 4'h1)
        begin
            report_error($sformatf("unexpected byte %02h with dc %0b after the expected list",
                                   got, got_dc));
        end
        else
        begin
            if (got !== expected[7:0] || got_dc !== expected[8])
                report_error($sformatf("byte %0d expected %02h with dc %0b, got %02h with dc %0b",
                                       started, expected[7:0], expected[8], got, got_dc));
            idx++;
            skip_to_next_byte();
        end
    endtask

    initial
    begin
        checks        = 0;
        errors        = 0;
        finished      = 1'b0;
        idx           = 0;
        group_errors  = 0;
        min_gap       = 0;
        gap_cnt       = 0;
        started       = 0;
        bit_cnt       = 0;
        shift_in      = 8'h00;
        prev_cs       = 1'b1;
        prev_sck      = 1'b0;
        done_seen     = 1'b0;
        level_flagged = 1'b0;
        $readmemh("tft_vectors.txt", vec);
        skip_to_next_byte();
    end

    // Falling clock edges see the registered SPI pins settled
    always @(negedge clk)
    begin
        if (rst)
        begin
            gap_cnt  = 0;
            prev_cs  = 1'b1;
            prev_sck = 1'b0;
        end
        else
        begin
            if (cs)
                gap_cnt++;
            if (!cs && prev_cs)
            begin
                started++;
                bit_cnt = 0;
                if (min_gap > 0)
                begin
                    checks++;
                    if (gap_cnt < min_gap)
                        report_error($sformatf("cs high for %0d cycles before byte %0d, need %0d",
                                               gap_cnt, started, min_gap));
                    min_gap = 0;
                end
                gap_cnt = 0;
            end
            if (!cs && sck && !prev_sck)
            begin
                shift_in = {shift_in[6:0], mosi};
                bit_cnt++;
                if (bit_cnt == 8)
                    compare_byte(shift_in, dc);
            end
            if (!level_flagged && ((started < init_bytes && init_done) ||
                                   (pixel_ready && !init_done)))
            begin
                level_flagged = 1'b1;
                report_error("init_done or pixel_ready high before the last window byte");
            end
            if (init_done)
                done_seen = 1'b1;
            else if (done_seen && !level_flagged)
            begin
                level_flagged = 1'b1;
                report_error("init_done fell after start-up had finished");
            end
            prev_cs  = cs;
            prev_sck = sck;
        end
    end

endmodule

// File: tb_tft_top.sv
`timescale 1ns/100ps
// Testbench for the TFT driver that drives pixels and frame starts from tft_vectors.txt
// while tft_checker compares every SPI byte.
module tb_tft_top;
    import tft_pkg::*;

    localparam int vec_depth = 128;
    localparam int init_timeout = 20000;
    localparam int ready_timeout = 200;
    localparam int drain_timeout = 2000;

    logic                   clk;
    logic                   rst;
    logic                   frame_start;
    logic [pixel_width-1:0] pixel;
    logic                   pixel_valid;
    logic                   pixel_ready;
    logic                   init_done;
    logic                   cs;
    logic                   sck;
    logic                   mosi;
    logic                   dc;
    int                     checks;
    int                     errors;
    logic                   finished;
    logic [23:0]            vec [0:vec_depth-1];
    logic                   ok;
    int                     i;

    tft_top #(
        .cycles_per_ms(4)
    ) tft_top_i (
        .clk        (clk),
        .rst        (rst),
        .frame_start(frame_start),
        .pixel      (pixel),
        .pixel_valid(pixel_valid),
        .pixel_ready(pixel_ready),
        .init_done  (init_done),
        .cs         (cs),
        .sck        (sck),
        .mosi       (mosi),
        .dc         (dc)
    );

    tft_checker tft_checker_i (
        .clk        (clk),
        .rst        (rst),
        .cs         (cs),
        .sck        (sck),
        .mosi       (mosi),
        .dc         (dc),
        .init_done  (init_done),
        .pixel_ready(pixel_ready),
        .checks     (checks),
        .errors     (errors),
        .finished   (finished)
    );

    always #50 clk = ~clk;

    function automatic logic watched_level(input int sel);
        case (sel)
            0:       return init_done;
            1:       return pixel_ready;
            default: return finished;
        endcase
    endfunction

    // Polls on falling edges, where the DUT outputs are stable
    task automatic wait_high(input int sel, input int limit, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!watched_level(sel) && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if (!watched_level(sel))
        begin
            $display("Timed out after %0d cycles waiting for %s", limit, what);
            ok = 1'b0;
        end
    endtask

    // The pixel is taken on the rising edge after pixel_ready was seen high
    task automatic send_pixel(input logic [pixel_width-1:0] p);
        pixel       = p;
        pixel_valid = 1'b1;
        wait_high(1, ready_timeout, "pixel_ready");
        @(posedge clk);
        #10;
    endtask

    initial
    begin
        clk         = 1'b0;
        rst         = 1'b1;
        frame_start = 1'b0;
        pixel       = '0;
        pixel_valid = 1'b0;
        ok          = 1'b1;
        $readmemh("tft_vectors.txt", vec);
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;

        wait_high(0, init_timeout, "init_done");
        @(posedge clk);
        #10;
        i = 0;
        while (ok && i < vec_depth && !$isunknown(vec[i]) && vec[i][23:20] != 4'h0)
        begin
            case (vec[i][23:20])
                4'h3: send_pixel(vec[i][pixel_width-1:0]);
                4'h4:
                begin
                    frame_start = 1'b1;
                    @(posedge clk);
                    #10;
                    frame_start = 1'b0;
                end
                4'h5:
                begin
                    pixel_valid = 1'b0;
                    repeat (vec[i][19:0]) @(posedge clk);
                    #10;
                end
                default: ;
            endcase
            i++;
        end
        pixel_valid = 1'b0;

        if (ok)
            wait_high(2, drain_timeout, "the checker to see every expected byte");
        // Once ready is back, no byte can still be queued behind the last one
        if (ok)
            wait_high(1, ready_timeout, "the SPI link to go idle");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (ok && finished && errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// File: tft_vectors.txt
// Word = kind nibble + 20-bit payload. 1 expected byte (bit 8 dc), 2 min cs-high cycles,
// 3 pixel to drive, 4 frame_start pulse, 5 idle cycles, 6 end of test, 0 end of list
2003FC
1000C0 100117 100115
1000C1 100141
1000C5 100100 100112 100180
100036 100148
10003A 100166
1000B0 100180
1000B1 1001A0
1000B6 100102 100102
1000E9 100100
1000F7 1001A9 100151 10012C 100182
100011 2003FC
100029
100021
100034 2003FC
10002A 100100 100100 100101 10013F
10002B 100100 100100 100101 1001DF
600001
// First pixels after start-up
33F015
10002C 1001FC 100100 100154
500004
32A57F
1001A8 100154 1001FC
600002
// New frame between pixels
500003 400000
301FA0
10002C 100104 1001F8 100180
310830
100140 100180 1001C0
600003
// Burst with pixel_valid held high
500006
33FFFF 300000 305294 333303
1001FC 1001FC 1001FC
100100 100100 100100
100114 100128 100150
1001CC 100130 10010C
600004
000000

// File: sources.f
tft_pkg.sv
ms_delay.sv
tft_spi_tx.sv
tft_init.sv
tft_pixel_stream.sv
tft_top.sv
tft_checker.sv
tb_tft_top.sv

// File: Bender.yml
package:
  name: tft_panel

sources:
  - tft_pkg.sv
  - ms_delay.sv
  - tft_spi_tx.sv
  - tft_init.sv
  - tft_pixel_stream.sv
  - tft_top.sv
  - target: test
    files:
      - tft_checker.sv
      - tb_tft_top.sv
